// ==== include/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// --------------------
// Datapath
// --------------------
`define CPU_WORD_W 16 // One memory word
`define CPU_ADDR_W 16 // Byte address, bit 0 always zero

// --------------------
// Cache geometry
// --------------------
`define CACHE_LINES 8 // Direct mapped, one way
`define LINE_WORDS 4 // Words fetched per refill

// --------------------
// Main memory
// --------------------
`define MEM_LAT 4 // Cycles from en to valid
`define MEM_WORDS 256 // Word depth

`endif

// ==== logic/cpu_pkg.sv ====
`default_nettype none
`include "cpu_consts.svh"

package cpu_pkg;

	// --------------------
	// Address split
	// --------------------
	// Byte address = {tag, index, word offset, 1'b0}
	localparam int OFF_W = $clog2(`LINE_WORDS);
	localparam int IDX_W = $clog2(`CACHE_LINES);
	localparam int TAG_W = `CPU_ADDR_W - IDX_W - OFF_W - 1;

	typedef logic [`CPU_WORD_W-1:0] word_t;
	typedef logic [`CPU_ADDR_W-1:0] addr_t;
	typedef logic [TAG_W-1:0] tag_t; // Bits above index
	typedef logic [IDX_W-1:0] index_t; // Line select
	typedef logic [OFF_W-1:0] off_t; // Word within line

	// --------------------
	// Port bundles
	// --------------------
	typedef struct packed {
		logic rd; // Load or fetch
		logic wr; // Store, never with rd
		addr_t addr;
		word_t wdata;
	} cache_req_t;

	typedef struct packed {
		logic busy; // Stall the pipeline
		word_t rdata; // Valid when busy low
	} cache_rsp_t;

	typedef struct packed {
		logic en; // Held until valid
		logic wr;
		addr_t addr;
		word_t wdata;
	} mem_req_t;

	typedef struct packed {
		logic valid; // One cycle pulse
		word_t rdata;
	} mem_rsp_t;

	// FSM states
	typedef enum logic [1:0] {IDLE, FILL, WRITE} cache_state_t;
	typedef enum logic [1:0] {ARB_IDLE, ARB_I, ARB_D} arb_state_t;

	// Field helpers
	function automatic tag_t addr_tag(addr_t a);
		return a[`CPU_ADDR_W-1 -: TAG_W];
	endfunction

	function automatic index_t addr_index(addr_t a);
		return a[OFF_W+1 +: IDX_W];
	endfunction

	function automatic off_t addr_off(addr_t a);
		return a[1 +: OFF_W];
	endfunction

	// Rebuild a word address inside a line
	function automatic addr_t line_addr(tag_t t, index_t i, off_t o);
		return {t, i, o, 1'b0};
	endfunction

endpackage

`default_nettype wire

// ==== logic/cache.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

// Direct-mapped write-through cache, no allocate on write miss
module cache (
	input  logic                clk,
	input  logic                arst_n,
	input  cpu_pkg::cache_req_t req, // From the pipeline
	output cpu_pkg::cache_rsp_t rsp,
	output cpu_pkg::mem_req_t   mem_req, // To the arbiter
	input  cpu_pkg::mem_rsp_t   mem_rsp,
	output logic                done // Transfer complete
);

	localparam cpu_pkg::off_t LAST_WORD = cpu_pkg::off_t'(`LINE_WORDS - 1);

	// --------------------
	// Storage
	// --------------------
	cpu_pkg::word_t data_q [`CACHE_LINES][`LINE_WORDS];
	cpu_pkg::tag_t tag_q [`CACHE_LINES];
	logic [`CACHE_LINES-1:0] valid_q; // Only these are reset

	cpu_pkg::cache_state_t state_q;
	cpu_pkg::cache_state_t state_d;
	cpu_pkg::off_t fill_cnt_q; // Next word of the refill
	logic wr_ack_q; // Write acked last cycle

	cpu_pkg::tag_t req_tag;
	cpu_pkg::index_t req_idx;
	cpu_pkg::off_t req_off;
	logic hit;
	logic fill_last;
	logic fill_beat; // A refill word arrives
	logic wr_beat; // Write acknowledged
	logic busy;

	// Lookup
	assign req_tag = cpu_pkg::addr_tag(req.addr);
	assign req_idx = cpu_pkg::addr_index(req.addr);
	assign req_off = cpu_pkg::addr_off(req.addr);
	assign hit = valid_q[req_idx] && (tag_q[req_idx] == req_tag);

	assign fill_last = (fill_cnt_q == LAST_WORD);
	assign fill_beat = (state_q == cpu_pkg::FILL) && mem_rsp.valid;
	assign wr_beat = (state_q == cpu_pkg::WRITE) && mem_rsp.valid;

	// --------------------
	// Control FSM
	// --------------------
	always_comb begin
		state_d = state_q;
		busy = 1'b0;
		case (state_q)
			cpu_pkg::IDLE: begin
				if (req.rd && !hit) begin // Miss stalls at once
					busy = 1'b1;
					state_d = cpu_pkg::FILL;
				end else if (req.wr && !wr_ack_q) begin
					busy = 1'b1;
					state_d = cpu_pkg::WRITE;
				end
			end
			cpu_pkg::FILL: begin
				busy = 1'b1;
				if (fill_beat && fill_last)
					state_d = cpu_pkg::IDLE; // Request hits next cycle
			end
			cpu_pkg::WRITE: begin
				busy = 1'b1;
				if (wr_beat)
					state_d = cpu_pkg::IDLE;
			end
			default: state_d = cpu_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= cpu_pkg::IDLE;
			fill_cnt_q <= '0;
			valid_q <= '0;
			wr_ack_q <= 1'b0;
		end else begin
			state_q <= state_d;
			wr_ack_q <= wr_beat; // Lets the held write complete
			// Line is invalid while it is being refilled
			if (state_q == cpu_pkg::IDLE && state_d == cpu_pkg::FILL)
				valid_q[req_idx] <= 1'b0;
			if (fill_beat) begin
				fill_cnt_q <= cpu_pkg::off_t'(fill_cnt_q + 1'b1); // Wraps to 0
				if (fill_last)
					valid_q[req_idx] <= 1'b1;
			end
		end
	end

	// --------------------
	// Arrays
	// --------------------
	always_ff @(posedge clk) begin
		if (fill_beat) begin
			data_q[req_idx][fill_cnt_q] <= mem_rsp.rdata;
			if (fill_last)
				tag_q[req_idx] <= req_tag;
		end else if (wr_beat && hit) begin
			data_q[req_idx][req_off] <= req.wdata; // Keep hitting line current
		end
	end

	// Memory side
	// Refill walks the line from word 0, write goes straight through
	assign mem_req = '{
		en:    (state_q == cpu_pkg::FILL) || (state_q == cpu_pkg::WRITE),
		wr:    (state_q == cpu_pkg::WRITE),
		addr:  (state_q == cpu_pkg::FILL) ?
		       cpu_pkg::line_addr(req_tag, req_idx, fill_cnt_q) : req.addr,
		wdata: req.wdata
	};

	assign done = (fill_beat && fill_last) || wr_beat;

	// Hit data straight from the arrays
	assign rsp = '{busy: busy, rdata: data_q[req_idx][req_off]};

endmodule

`default_nettype wire

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

// Shares the single memory port between the two caches
module mem_arbiter (
	input  logic              clk,
	input  logic              arst_n,
	input  cpu_pkg::mem_req_t i_mem_req, // I-cache side
	input  cpu_pkg::mem_req_t d_mem_req, // D-cache side
	input  logic              i_done,
	input  logic              d_done,
	output cpu_pkg::mem_rsp_t i_mem_rsp,
	output cpu_pkg::mem_rsp_t d_mem_rsp,
	output cpu_pkg::mem_req_t mem_req, // To main memory
	input  cpu_pkg::mem_rsp_t mem_rsp
);

	cpu_pkg::arb_state_t state_q;
	cpu_pkg::arb_state_t state_d;

	// --------------------
	// Grant FSM
	// --------------------
	// Fetch wins a tie, grant held to the owner's done
	always_comb begin
		state_d = state_q;
		case (state_q)
			cpu_pkg::ARB_IDLE: begin
				if (i_mem_req.en)
					state_d = cpu_pkg::ARB_I;
				else if (d_mem_req.en)
					state_d = cpu_pkg::ARB_D;
			end
			cpu_pkg::ARB_I: begin
				if (i_done)
					state_d = cpu_pkg::ARB_IDLE; // One idle cycle between owners
			end
			cpu_pkg::ARB_D: begin
				if (d_done)
					state_d = cpu_pkg::ARB_IDLE;
			end
			default: state_d = cpu_pkg::ARB_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			state_q <= cpu_pkg::ARB_IDLE;
		else
			state_q <= state_d;
	end

	// --------------------
	// Steering
	// --------------------
	always_comb begin
		case (state_q)
			cpu_pkg::ARB_I: mem_req = i_mem_req;
			cpu_pkg::ARB_D: mem_req = d_mem_req;
			default:        mem_req = '0; // Port quiet while idle
		endcase
	end

	// Response goes to the owner only
	assign i_mem_rsp = '{
		valid: mem_rsp.valid && (state_q == cpu_pkg::ARB_I),
		rdata: mem_rsp.rdata
	};
	assign d_mem_rsp = '{
		valid: mem_rsp.valid && (state_q == cpu_pkg::ARB_D),
		rdata: mem_rsp.rdata
	};

endmodule

`default_nettype wire

// ==== logic/main_mem.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

// Single-port word memory with fixed access latency
module main_mem (
	input  logic              clk,
	input  logic              arst_n,
	input  cpu_pkg::mem_req_t req,
	output cpu_pkg::mem_rsp_t rsp
);

	localparam int LAT_W = $clog2(`MEM_LAT + 1);
	localparam int MEM_AW = $clog2(`MEM_WORDS);

	// --------------------
	// Storage
	// --------------------
	cpu_pkg::word_t mem_q [`MEM_WORDS]; // Contents survive reset
	cpu_pkg::word_t rdata_q;

	logic [LAT_W-1:0] lat_cnt_q; // Cycles of en seen so far
	logic valid_q;
	logic [MEM_AW-1:0] word_addr;
	logic fire; // Access happens at this edge

	assign word_addr = req.addr[MEM_AW:1]; // Drop byte bit

	// Last wait cycle of the current access
	// Cycle with valid high is not counted
	assign fire = req.en && !valid_q && (lat_cnt_q == LAT_W'(`MEM_LAT - 1));

	// --------------------
	// Latency counter
	// --------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			lat_cnt_q <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= fire; // One cycle pulse
			if (fire || valid_q || !req.en)
				lat_cnt_q <= '0; // Restart for the next access
			else
				lat_cnt_q <= lat_cnt_q + 1'b1;
		end
	end

	// Array access
	always_ff @(posedge clk) begin
		if (fire) begin
			if (req.wr)
				mem_q[word_addr] <= req.wdata;
			else
				rdata_q <= mem_q[word_addr];
		end
	end

	assign rsp = '{valid: valid_q, rdata: rdata_q};

endmodule

`default_nettype wire

// ==== logic/cpu_mem_sys.sv ====
`timescale 1ns/1ps
`default_nettype none

// Memory side of the CPU
// I and D caches share main memory through the arbiter
module cpu_mem_sys (
	input  logic                clk,
	input  logic                arst_n,
	input  cpu_pkg::cache_req_t i_req, // Fetch port
	input  cpu_pkg::cache_req_t d_req, // Load and store port
	output cpu_pkg::cache_rsp_t i_rsp,
	output cpu_pkg::cache_rsp_t d_rsp
);

	// --------------------
	// Cache to arbiter
	// --------------------
	cpu_pkg::mem_req_t i_mem_req;
	cpu_pkg::mem_rsp_t i_mem_rsp;
	logic i_done;

	cpu_pkg::mem_req_t d_mem_req;
	cpu_pkg::mem_rsp_t d_mem_rsp;
	logic d_done;

	// Arbiter to memory
	cpu_pkg::mem_req_t mem_req;
	cpu_pkg::mem_rsp_t mem_rsp;

	cache i_cache_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.req     (i_req),
		.rsp     (i_rsp),
		.mem_req (i_mem_req),
		.mem_rsp (i_mem_rsp),
		.done    (i_done)
	);

	cache d_cache_i (
		.clk     (clk),
		.arst_n  (arst_n),
		.req     (d_req),
		.rsp     (d_rsp),
		.mem_req (d_mem_req),
		.mem_rsp (d_mem_rsp),
		.done    (d_done)
	);

	mem_arbiter mem_arbiter_i (
		.clk       (clk),
		.arst_n    (arst_n),
		.i_mem_req (i_mem_req),
		.d_mem_req (d_mem_req),
		.i_done    (i_done),
		.d_done    (d_done),
		.i_mem_rsp (i_mem_rsp),
		.d_mem_rsp (d_mem_rsp),
		.mem_req   (mem_req),
		.mem_rsp   (mem_rsp)
	);

	main_mem main_mem_i (
		.clk    (clk),
		.arst_n (arst_n),
		.req    (mem_req),
		.rsp    (mem_rsp)
	);

endmodule

`default_nettype wire

// ==== tests/cpu_mem_sys_props.sv ====
`timescale 1ns/1ps
`default_nettype none

// Protocol checks on the memory system
module cpu_mem_sys_props (
	input logic                clk,
	input logic                arst_n,
	input cpu_pkg::cache_req_t i_req,
	input cpu_pkg::cache_req_t d_req,
	input cpu_pkg::cache_rsp_t i_rsp,
	input cpu_pkg::cache_rsp_t d_rsp,
	input cpu_pkg::mem_req_t   i_mem_req,
	input cpu_pkg::mem_req_t   d_mem_req,
	input logic                i_done,
	input logic                d_done,
	input cpu_pkg::mem_req_t   mem_req, // Arbiter output
	input cpu_pkg::mem_rsp_t   mem_rsp
);

	int assert_fails = 0; // Failed assertions so far

	// --------------------
	// Pipeline side
	// --------------------
	rd_wr_excl: assert property (@(posedge clk) disable iff (!arst_n)
		!(i_req.rd && i_req.wr) && !(d_req.rd && d_req.wr))
		else begin
			assert_fails++;
			$error("rd and wr high together on a pipeline port");
		end

	// Ports quiet in the first cycle out of reset
	busy_after_rst: assert property (@(posedge clk)
		$rose(arst_n) |-> !i_rsp.busy && !d_rsp.busy)
		else begin
			assert_fails++;
			$error("busy high in the first cycle after reset release");
		end

	// --------------------
	// Memory side
	// --------------------
	// Port stays with the fetch cache until its done pulse
	grant_hold_i: assert property (@(posedge clk) disable iff (!arst_n)
		mem_req.en && mem_req == i_mem_req && mem_req != d_mem_req && !i_done
		|=> mem_req.en && mem_req == i_mem_req)
		else begin
			assert_fails++;
			$error("memory port left the fetch cache before its transfer ended");
		end

	// Same rule for the data cache
	grant_hold_d: assert property (@(posedge clk) disable iff (!arst_n)
		mem_req.en && mem_req == d_mem_req && mem_req != i_mem_req && !d_done
		|=> mem_req.en && mem_req == d_mem_req)
		else begin
			assert_fails++;
			$error("memory port left the data cache before its transfer ended");
		end

	valid_with_en: assert property (@(posedge clk) disable iff (!arst_n)
		mem_rsp.valid |-> mem_req.en)
		else begin
			assert_fails++;
			$error("memory valid high without en");
		end

endmodule

bind cpu_mem_sys cpu_mem_sys_props props_i (
	.clk       (clk),
	.arst_n    (arst_n),
	.i_req     (i_req),
	.d_req     (d_req),
	.i_rsp     (i_rsp),
	.d_rsp     (d_rsp),
	.i_mem_req (i_mem_req),
	.d_mem_req (d_mem_req),
	.i_done    (i_done),
	.d_done    (d_done),
	.mem_req   (mem_req),
	.mem_rsp   (mem_rsp)
);

`default_nettype wire

// ==== tests/cpu_mem_sys_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_consts.svh"

module cpu_mem_sys_tb;

	localparam int TEST_WORDS = 64; // Word range under test
	localparam int RD_OPS = 40; // Random reads per port
	localparam int HIT_OPS = 8;
	localparam int CONT_OPS = 24; // Accesses per port while contending
	localparam int BUSY_LIMIT = `LINE_WORDS * (`MEM_LAT + 3) * 2;
	localparam int TOTAL_OPS = 1 + TEST_WORDS + 2 * RD_OPS + 7 * HIT_OPS + 2 * CONT_OPS;
	localparam int TIMEOUT_CYCLES = TOTAL_OPS * BUSY_LIMIT + 10;

	logic clk;
	logic arst_n;
	cpu_pkg::cache_req_t i_req;
	cpu_pkg::cache_req_t d_req;
	cpu_pkg::cache_rsp_t i_rsp;
	cpu_pkg::cache_rsp_t d_rsp;

	logic [31:0] lcg_state;
	cpu_pkg::word_t model [TEST_WORDS]; // Reference memory
	cpu_pkg::addr_t i_addr [CONT_OPS];
	cpu_pkg::addr_t d_addr [CONT_OPS];
	int mismatch_errs = 0;
	int protocol_errs = 0;
	int unsigned cycle_cnt = 0;

	cpu_mem_sys dut_i (
		.clk    (clk),
		.arst_n (arst_n),
		.i_req  (i_req),
		.d_req  (d_req),
		.i_rsp  (i_rsp),
		.d_rsp  (d_rsp)
	);

	always #20 clk = ~clk; // 40 ns period

	// --------------------
	// Helpers
	// --------------------
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic cpu_pkg::addr_t rand_addr();
		int unsigned idx;
		idx = (lcg_next() >> 16) % TEST_WORDS; // Word, not byte
		return cpu_pkg::addr_t'(idx << 1);
	endfunction

	task automatic check_word(input string name, input cpu_pkg::word_t exp,
		input cpu_pkg::word_t act);
		if (act !== exp) begin
			mismatch_errs++;
			$display("MISMATCH %s: expected 0x%04h, actual 0x%04h", name, exp, act);
		end
	endtask

	task automatic check_busy(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			mismatch_errs++;
			$display("MISMATCH %s: expected busy %0b, actual busy %0b", name, exp, act);
		end
	endtask

	// One pipeline access, held while busy
	task automatic run_access(input logic on_i, input logic is_wr, input cpu_pkg::addr_t addr,
		input cpu_pkg::word_t wdata, output cpu_pkg::word_t rdata, output logic first_busy);
		cpu_pkg::cache_req_t req;
		cpu_pkg::cache_rsp_t rsp;
		int waited;
		req = '{rd: !is_wr, wr: is_wr, addr: addr, wdata: wdata};
		waited = 0;
		@(posedge clk);
		if (on_i) i_req <= req;
		else d_req <= req;
		@(negedge clk); // Mid cycle, outputs settled
		rsp = on_i ? i_rsp : d_rsp;
		first_busy = rsp.busy;
		while (rsp.busy && waited < BUSY_LIMIT) begin
			@(negedge clk);
			rsp = on_i ? i_rsp : d_rsp;
			waited++;
		end
		if (rsp.busy) begin
			protocol_errs++;
			$display("ERROR: %s port busy for more than %0d cycles at address 0x%04h",
				on_i ? "fetch" : "data", BUSY_LIMIT, addr);
		end
		rdata = rsp.rdata;
		@(posedge clk); // Access completes at this edge
		if (on_i) i_req <= '0;
		else d_req <= '0;
	endtask

	// --------------------
	// Stimulus
	// --------------------
	initial begin : stimulus
		cpu_pkg::addr_t a;
		cpu_pkg::word_t rd;
		cpu_pkg::word_t nw;
		logic b;
		clk = 1'b0;
		arst_n = 1'b0;
		i_req = '0;
		d_req = '0;
		lcg_state = 32'd34;
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		check_busy("reset_fetch", 1'b0, i_rsp.busy);
		check_busy("reset_data", 1'b0, d_rsp.busy);
		a = rand_addr();
		run_access(1'b0, 1'b0, a, '0, rd, b);
		check_busy("first_read", 1'b1, b); // All lines invalid
		for (int w = 0; w < TEST_WORDS; w++) begin // Fill memory and model
			nw = cpu_pkg::word_t'(lcg_next() >> 16);
			run_access(1'b0, 1'b1, cpu_pkg::addr_t'(w * 2), nw, rd, b);
			model[w] = nw;
		end
		repeat (RD_OPS) begin
			a = rand_addr();
			run_access(1'b0, 1'b0, a, '0, rd, b);
			check_word("data_read", model[a[6:1]], rd);
		end
		// Read, write, read on one address
		repeat (HIT_OPS) begin
			a = rand_addr();
			nw = cpu_pkg::word_t'(lcg_next() >> 16);
			run_access(1'b0, 1'b0, a, '0, rd, b);
			run_access(1'b0, 1'b1, a, nw, rd, b);
			model[a[6:1]] = nw;
			run_access(1'b0, 1'b0, a, '0, rd, b);
			check_busy("write_hit_busy", 1'b0, b);
			check_word("write_hit", nw, rd);
		end
		// No writes from here on, fetch side stays coherent
		repeat (RD_OPS) begin
			a = rand_addr();
			run_access(1'b1, 1'b0, a, '0, rd, b);
			check_word("fetch_read", model[a[6:1]], rd);
		end
		repeat (HIT_OPS) begin
			a = rand_addr();
			run_access(1'b1, 1'b0, a, '0, rd, b);
			run_access(1'b1, 1'b0, a, '0, rd, b); // Line just filled
			check_busy("fetch_hit_busy", 1'b0, b);
			check_word("fetch_hit", model[a[6:1]], rd);
			run_access(1'b0, 1'b0, a, '0, rd, b);
			run_access(1'b0, 1'b0, a, '0, rd, b);
			check_busy("data_hit_busy", 1'b0, b);
			check_word("data_hit", model[a[6:1]], rd);
		end
		for (int k = 0; k < CONT_OPS; k++) begin
			i_addr[k] = rand_addr();
			d_addr[k] = rand_addr();
		end
		// Both ports at once
		fork
			begin : fetch_side
				cpu_pkg::word_t fr;
				logic fb;
				for (int k = 0; k < CONT_OPS; k++) begin
					run_access(1'b1, 1'b0, i_addr[k], '0, fr, fb);
					check_word("contend_fetch", model[i_addr[k][6:1]], fr);
				end
			end
			begin : data_side
				cpu_pkg::word_t dr;
				logic db;
				for (int k = 0; k < CONT_OPS; k++) begin
					run_access(1'b0, 1'b0, d_addr[k], '0, dr, db);
					check_word("contend_data", model[d_addr[k][6:1]], dr);
				end
			end
		join
		$display("Errors: %0d mismatch, %0d protocol, %0d assertion",
			mismatch_errs, protocol_errs, dut_i.props_i.assert_fails);
		if (mismatch_errs == 0 && protocol_errs == 0 && dut_i.props_i.assert_fails == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// Run limit
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Result: FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== cpu_mem_sys.f ====
+incdir+include
logic/cpu_pkg.sv
logic/cache.sv
logic/mem_arbiter.sv
logic/main_mem.sv
logic/cpu_mem_sys.sv
tests/cpu_mem_sys_props.sv
tests/cpu_mem_sys_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_mem_sys

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/cpu_pkg.sv
      - logic/cache.sv
      - logic/mem_arbiter.sv
      - logic/main_mem.sv
      - logic/cpu_mem_sys.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/cpu_mem_sys_props.sv
      - tests/cpu_mem_sys_tb.sv
